/* source/input_cfg.svh */
`ifndef INPUT_CFG_SVH
`define INPUT_CFG_SVH

// fire buttons per player
`define INPUT_BUTTONS 2

// 1 means the core expects active-low inputs
`define INPUT_ACTIVE_LOW 1

// extra buttons push start, coin and pause up
`define INPUT_START_BIT (6 + (`INPUT_BUTTONS - 2))
`define INPUT_COIN_BIT  (7 + (`INPUT_BUTTONS - 2))
`define INPUT_PAUSE_BIT (8 + (`INPUT_BUTTONS - 2))

// fire passes while the frame count is above this
`define INPUT_AUTOFIRE_LIMIT 5

`endif

/* source/input_pkg.sv */
package input_pkg;

    // direction bits in order right, left, down, up (up at bit 0)
    typedef logic [3:0] dir_t;

    // raw active-high word from the board joystick
    typedef logic [15:0] board_joy_t;

    // word toward the game core in core polarity
    typedef logic [9:0] game_joy_t;

    // one bit per player
    typedef logic [3:0] player_bits_t;

    // counts vs rises for the autofire gate
    typedef logic [2:0] fire_cnt_t;

    typedef enum logic [1:0] {
        st_run,
        st_paused,
        st_step     // one frame runs and then back to paused
    } pause_state_t;

endpackage

/* source/pause_req_if.sv */
`timescale 1ns/1ns

interface pause_req_if;

    logic toggle;         // pause key or joystick pause rose
    logic osd_change;     // menu pause moved
    logic osd_level;      // menu pause value
    logic service_edge;   // service key rose

    modport src (
        output toggle,
        output osd_change,
        output osd_level,
        output service_edge
    );

    // single-cycle pulses sampled as they come
    modport dst (
        input toggle,
        input osd_change,
        input osd_level,
        input service_edge
    );

endinterface

/* source/joy_4way_filter.sv */
`timescale 1ns/1ns

module joy_4way_filter (
    input  logic            clk,
    input  logic            rst,
    input  logic            enable,
    input  input_pkg::dir_t dir_in,
    output input_pkg::dir_t dir_out
);
    import input_pkg::*;

    dir_t last_dir;   // last direction that was pressed alone
    logic multi;      // two or more directions held

    // clearing the lowest set bit leaves something only for diagonals
    assign multi = |(dir_in & (dir_in - 4'd1));

    // diagonal keeps the older direction while it is still held
    assign dir_out = (enable && multi) ? (last_dir & dir_in) : dir_in;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_dir <= '0;
        end else if (!multi && |dir_in) begin
            last_dir <= dir_in;
        end
    end

endmodule

/* source/frame_timer.sv */
`timescale 1ns/1ns

`include "input_cfg.svh"

module frame_timer (
    input  logic clk,
    input  logic rst,
    input  logic vs,
    input  logic autofire_en,
    output logic vbl_end,
    output logic autofire
);
    import input_pkg::*;

    logic      vs_l;
    logic      vbl_start;
    fire_cnt_t fire_cnt;

    assign vbl_start = vs && !vs_l;
    assign vbl_end   = !vs && vs_l;   // vs falling

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vs_l     <= 1'b0;
            fire_cnt <= '0;
            autofire <= 1'b1;
        end else begin
            vs_l <= vs;
            if (vbl_start) begin
                fire_cnt <= fire_cnt + 3'd1;   // wraps every 8 frames
            end
            // 2 frames out of 8 let fire through
            autofire <= !autofire_en || (fire_cnt > 3'(`INPUT_AUTOFIRE_LIMIT));
        end
    end

endmodule

/* source/pause_fsm.sv */
`timescale 1ns/1ns

module pause_fsm (
    input  logic           clk,
    input  logic           rst,
    input  logic           downloading,
    input  logic           lock,
    pause_req_if.dst       req,
    input  logic           vbl_end,
    output logic           game_pause
);
    import input_pkg::*;

    pause_state_t state;
    pause_state_t state_nx;

    always_comb begin
        state_nx = state;
        case (state)
            st_run: begin
                if (req.toggle) begin
                    state_nx = st_paused;
                end
            end
            st_paused: begin
                // service while paused advances one frame
                if (req.service_edge) begin
                    state_nx = st_step;
                end else if (req.toggle) begin
                    state_nx = st_run;
                end
            end
            st_step: begin
                if (vbl_end) begin
                    state_nx = st_paused;   // frame done
                end
            end
            default: begin
                state_nx = st_run;
            end
        endcase

        // the menu wins over the toggles
        if (req.osd_change) begin
            state_nx = req.osd_level ? st_paused : st_run;
        end

        if (downloading || lock) begin
            state_nx = st_run;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_run;
        end else begin
            state <= state_nx;
        end
    end

    assign game_pause = (state == st_paused);

endmodule

/* source/input_merger.sv */
`timescale 1ns/1ns

`include "input_cfg.svh"

module input_merger (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dip_flip,
    input  logic                    rot_control,
    input  logic                    lock,
    input  logic                    key_pause,
    input  logic                    osd_pause,
    input  logic                    key_reset,
    input  logic                    key_service,
    input  logic                    key_test,
    input  logic                    autofire,
    input  input_pkg::board_joy_t   board_joy1,
    input  input_pkg::board_joy_t   board_joy2,
    input  input_pkg::board_joy_t   board_joy3,
    input  input_pkg::board_joy_t   board_joy4,
    input  input_pkg::player_bits_t board_coin,
    input  input_pkg::player_bits_t board_start,
    input  input_pkg::dir_t         dir1,
    input  input_pkg::dir_t         dir2,
    input  input_pkg::dir_t         dir3,
    input  input_pkg::dir_t         dir4,
    input  input_pkg::game_joy_t    key_joy1,
    input  input_pkg::game_joy_t    key_joy2,
    input  input_pkg::game_joy_t    key_joy3,
    input  input_pkg::player_bits_t key_coin,
    input  input_pkg::player_bits_t key_start,
    output input_pkg::game_joy_t    game_joy1,
    output input_pkg::game_joy_t    game_joy2,
    output input_pkg::game_joy_t    game_joy3,
    output input_pkg::game_joy_t    game_joy4,
    output input_pkg::player_bits_t game_coin,
    output input_pkg::player_bits_t game_start,
    output logic                    game_service,
    output logic                    game_test,
    output logic                    soft_rst,
    pause_req_if.src                req
);
    import input_pkg::*;

    localparam logic POL = `INPUT_ACTIVE_LOW;

    board_joy_t   joy_s1, joy_s2, joy_s3, joy_s4;
    game_joy_t    key_s1, key_s2, key_s3;
    player_bits_t coin_s, start_s, kcoin_s, kstart_s;
    player_bits_t joy_coin, joy_start;
    logic         pause_s, osd_s, reset_s, service_s, test_s;
    logic         pause_l, osd_l, reset_l, service_l, joyp_l;
    logic         joy_pause;

    // fire gate, then rotation, then core polarity
    function automatic game_joy_t apply_rot(input game_joy_t j, input logic rot,
                                            input logic flip, input logic fire_ok);
        game_joy_t r;
        r    = j;
        r[4] = j[4] & fire_ok;
        if (rot) begin
            if (flip) begin
                r[3:0] = {j[3], j[2], j[0], j[1]};   // up and down swap
            end else begin
                r[3:0] = {j[2], j[3], j[0], j[1]};
            end
        end
        return r ^ {$bits(game_joy_t){POL}};
    endfunction

    // sync stage with the filtered directions in place of the raw ones
    always_ff @(posedge clk) begin
        joy_s1   <= {board_joy1[15:4], dir1};
        joy_s2   <= {board_joy2[15:4], dir2};
        joy_s3   <= {board_joy3[15:4], dir3};
        joy_s4   <= {board_joy4[15:4], dir4};
        key_s1   <= key_joy1;
        key_s2   <= key_joy2;
        key_s3   <= key_joy3;
        coin_s   <= board_coin;
        start_s  <= board_start;
        kcoin_s  <= key_coin;
        kstart_s <= key_start;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {pause_s, osd_s, reset_s, service_s, test_s} <= '0;
            {pause_l, osd_l, reset_l, service_l, joyp_l} <= '0;
        end else begin
            pause_s   <= key_pause;
            osd_s     <= osd_pause;
            reset_s   <= key_reset;
            service_s <= key_service;
            test_s    <= key_test;
            pause_l   <= pause_s;    // previous values for edges
            osd_l     <= osd_s;
            reset_l   <= reset_s;
            service_l <= service_s;
            joyp_l    <= joy_pause;
        end
    end

    assign joy_pause = joy_s1[`INPUT_PAUSE_BIT] | joy_s2[`INPUT_PAUSE_BIT];
    assign joy_coin  = {joy_s4[`INPUT_COIN_BIT], joy_s3[`INPUT_COIN_BIT],
                        joy_s2[`INPUT_COIN_BIT], joy_s1[`INPUT_COIN_BIT]};
    assign joy_start = {joy_s4[`INPUT_START_BIT], joy_s3[`INPUT_START_BIT],
                        joy_s2[`INPUT_START_BIT], joy_s1[`INPUT_START_BIT]};

    assign req.toggle       = (pause_s && !pause_l) || (joy_pause && !joyp_l);
    assign req.osd_change   = osd_s ^ osd_l;
    assign req.osd_level    = osd_s;
    assign req.service_edge = service_s && !service_l;

    // output register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_joy1    <= {$bits(game_joy_t){POL}};
            game_joy2    <= {$bits(game_joy_t){POL}};
            game_joy3    <= {$bits(game_joy_t){POL}};
            game_joy4    <= {$bits(game_joy_t){POL}};
            game_coin    <= {$bits(player_bits_t){POL}};
            game_start   <= {$bits(player_bits_t){POL}};
            game_service <= POL;
            game_test    <= POL;
            soft_rst     <= 1'b0;
        end else begin
            soft_rst <= reset_s && !reset_l;
            if (lock) begin   // locked core sees nothing pressed
                game_joy1    <= {$bits(game_joy_t){POL}};
                game_joy2    <= {$bits(game_joy_t){POL}};
                game_joy3    <= {$bits(game_joy_t){POL}};
                game_joy4    <= {$bits(game_joy_t){POL}};
                game_coin    <= {$bits(player_bits_t){POL}};
                game_start   <= {$bits(player_bits_t){POL}};
                game_service <= POL;
                game_test    <= POL;
            end else begin
                game_joy1    <= apply_rot(joy_s1[9:0] | key_s1, rot_control, dip_flip, autofire);
                game_joy2    <= apply_rot(joy_s2[9:0] | key_s2, rot_control, dip_flip, autofire);
                game_joy3    <= apply_rot(joy_s3[9:0] | key_s3, rot_control, dip_flip, autofire);
                game_joy4    <= apply_rot(joy_s4[9:0], rot_control, dip_flip, autofire);
                game_coin    <= {$bits(player_bits_t){POL}} ^ (joy_coin | kcoin_s | coin_s);
                game_start   <= {$bits(player_bits_t){POL}} ^ (joy_start | kstart_s | start_s);
                game_service <= service_s ^ POL;
                game_test    <= test_s ^ POL;
            end
        end
    end

endmodule

/* source/arcade_inputs_top.sv */
`timescale 1ns/1ns

module arcade_inputs_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    vs,
    input  logic                    dip_flip,
    input  logic                    rot_control,
    input  logic                    autofire0,
    input  logic                    downloading,
    input  logic                    en4way,
    input  logic                    lock,
    input  logic                    key_pause,
    input  logic                    osd_pause,
    input  logic                    key_reset,
    input  logic                    key_service,
    input  logic                    key_test,
    input  input_pkg::board_joy_t   board_joy1,
    input  input_pkg::board_joy_t   board_joy2,
    input  input_pkg::board_joy_t   board_joy3,
    input  input_pkg::board_joy_t   board_joy4,
    input  input_pkg::player_bits_t board_coin,
    input  input_pkg::player_bits_t board_start,
    input  input_pkg::game_joy_t    key_joy1,
    input  input_pkg::game_joy_t    key_joy2,
    input  input_pkg::game_joy_t    key_joy3,
    input  input_pkg::player_bits_t key_coin,
    input  input_pkg::player_bits_t key_start,
    output input_pkg::game_joy_t    game_joy1,
    output input_pkg::game_joy_t    game_joy2,
    output input_pkg::game_joy_t    game_joy3,
    output input_pkg::game_joy_t    game_joy4,
    output input_pkg::player_bits_t game_coin,
    output input_pkg::player_bits_t game_start,
    output logic                    game_service,
    output logic                    game_test,
    output logic                    soft_rst,
    output logic                    game_pause
);
    import input_pkg::*;

    dir_t dir1, dir2, dir3, dir4;
    logic vbl_end;
    logic autofire;

    pause_req_if pause_req ();

    joy_4way_filter u_4way1 (.clk, .rst, .enable(en4way), .dir_in(board_joy1[3:0]), .dir_out(dir1));
    joy_4way_filter u_4way2 (.clk, .rst, .enable(en4way), .dir_in(board_joy2[3:0]), .dir_out(dir2));
    joy_4way_filter u_4way3 (.clk, .rst, .enable(en4way), .dir_in(board_joy3[3:0]), .dir_out(dir3));
    joy_4way_filter u_4way4 (.clk, .rst, .enable(en4way), .dir_in(board_joy4[3:0]), .dir_out(dir4));

    frame_timer u_timer (
        .clk, .rst, .vs,
        .autofire_en (autofire0),
        .vbl_end     (vbl_end),
        .autofire    (autofire)
    );

    input_merger u_merger (
        .clk, .rst, .dip_flip, .rot_control, .lock,
        .key_pause, .osd_pause, .key_reset, .key_service, .key_test,
        .autofire,
        .board_joy1, .board_joy2, .board_joy3, .board_joy4,
        .board_coin, .board_start,
        .dir1, .dir2, .dir3, .dir4,
        .key_joy1, .key_joy2, .key_joy3, .key_coin, .key_start,
        .game_joy1, .game_joy2, .game_joy3, .game_joy4,
        .game_coin, .game_start, .game_service, .game_test, .soft_rst,
        .req         (pause_req.src)
    );

    pause_fsm u_pause (
        .clk, .rst, .downloading, .lock,
        .req         (pause_req.dst),
        .vbl_end     (vbl_end),
        .game_pause  (game_pause)
    );

endmodule

/* tb/arcade_inputs_props.sv */
`timescale 1ns/1ns

`include "input_cfg.svh"

module arcade_inputs_props (
    input logic clk, rst, vs, autofire0, en4way, lock, downloading,
    input logic rot_control, dip_flip, key_pause, osd_pause, key_reset, key_service, key_test,
    input input_pkg::board_joy_t   board_joy1, board_joy2, board_joy3, board_joy4,
    input input_pkg::game_joy_t    key_joy1, key_joy2, key_joy3,
    input input_pkg::player_bits_t board_coin, board_start, key_coin, key_start,
    input input_pkg::game_joy_t    game_joy1, game_joy2, game_joy3, game_joy4,
    input input_pkg::player_bits_t game_coin, game_start,
    input logic game_pause, soft_rst, game_service, game_test
);
    import input_pkg::*;

    localparam logic POL = `INPUT_ACTIVE_LOW;

    int unsigned  err_cnt = 0;   // failures seen so far
    board_joy_t   bj [4];
    game_joy_t    kj [4];
    game_joy_t    gj [4];
    player_bits_t coin_d1, coin_d2, start_d1, start_d2;
    logic         rot_d1, flip_d1, lock_d1, af_ref, af_d1, vs_q, svc_q, step_ref;
    fire_cnt_t    cnt_ref;
    logic [2:0]   age;
    logic         ready;

    assign bj = '{board_joy1, board_joy2, board_joy3, board_joy4};
    assign kj = '{key_joy1, key_joy2, key_joy3, 10'd0};   // no keyboard for player 4
    assign gj = '{game_joy1, game_joy2, game_joy3, game_joy4};
    assign ready = (age >= 3'd4);

    function automatic game_joy_t expect_joy(input game_joy_t j, input logic rot,
                                             input logic flip, input logic fire_ok);
        game_joy_t e;
        e    = j;
        e[4] = j[4] && fire_ok;
        if (rot) begin
            e[0] = j[1];   // up takes down
            e[1] = j[0];
            e[2] = flip ? j[2] : j[3];
            e[3] = flip ? j[3] : j[2];
        end
        return e ^ {10{POL}};
    endfunction

    // diagonals keep only the older single direction
    function automatic dir_t filter_dir(input dir_t d, input dir_t last, input logic en);
        return (en && $countones(d) > 1) ? (d & last) : d;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            age      <= '0;
            cnt_ref  <= '0;
            af_ref   <= 1'b1;
            vs_q     <= 1'b0;
            svc_q    <= 1'b0;
            step_ref <= 1'b0;
        end else begin
            if (age != 3'd7) begin
                age <= age + 3'd1;
            end
            vs_q  <= vs;
            svc_q <= key_service;
            if (vs && !vs_q) begin
                cnt_ref <= cnt_ref + 3'd1;
            end
            af_ref <= !autofire0 || (cnt_ref inside {3'd6, 3'd7});
            if (lock || downloading || (!vs && vs_q)) begin
                step_ref <= 1'b0;   // frame ended or forced run
            end else if (game_pause && key_service && !svc_q) begin
                step_ref <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        coin_d1  <= board_coin | key_coin | {bj[3][`INPUT_COIN_BIT], bj[2][`INPUT_COIN_BIT],
                                             bj[1][`INPUT_COIN_BIT], bj[0][`INPUT_COIN_BIT]};
        start_d1 <= board_start | key_start | {bj[3][`INPUT_START_BIT], bj[2][`INPUT_START_BIT],
                                               bj[1][`INPUT_START_BIT], bj[0][`INPUT_START_BIT]};
        coin_d2  <= coin_d1;
        start_d2 <= start_d1;
        rot_d1   <= rot_control;
        flip_d1  <= dip_flip;
        lock_d1  <= lock;
        af_d1    <= af_ref;
    end

    for (genvar p = 0; p < 4; p++) begin : g_player
        dir_t      last;
        game_joy_t d1, d2;

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                last <= '0;
            end else if ($countones(bj[p][3:0]) == 1) begin
                last <= bj[p][3:0];
            end
        end

        always_ff @(posedge clk) begin
            d1 <= {bj[p][9:4], filter_dir(bj[p][3:0], last, en4way)} | kj[p];
            d2 <= d1;
        end

        joy_map: assert property (@(posedge clk) disable iff (rst)
            ready && !lock_d1 |-> gj[p] == expect_joy(d2, rot_d1, flip_d1, af_d1))
            else begin
                err_cnt++;
                $error("Error at %0t: game_joy%0d is %h, expected %h", $time, p + 1, gj[p],
                       expect_joy(d2, rot_d1, flip_d1, af_d1));
            end
    end

    coin_map: assert property (@(posedge clk) disable iff (rst)
        ready && !lock_d1 |-> game_coin == ({4{POL}} ^ coin_d2)
                              && game_start == ({4{POL}} ^ start_d2))
        else begin
            err_cnt++;
            $error("Error at %0t: game_coin/game_start are %h/%h, expected %h/%h", $time,
                   game_coin, game_start, {4{POL}} ^ coin_d2, {4{POL}} ^ start_d2);
        end

    svc_map: assert property (@(posedge clk) disable iff (rst)
        ready && !lock_d1 |-> game_service == (POL ^ $past(key_service, 2))
                              && game_test == (POL ^ $past(key_test, 2)))
        else begin
            err_cnt++;
            $error("Error at %0t: game_service/game_test are %b/%b, expected %b/%b", $time,
                   game_service, game_test, POL ^ $past(key_service, 2),
                   POL ^ $past(key_test, 2));
        end

    pause_toggle: assert property (@(posedge clk) disable iff (rst)
        ready && $past(key_pause, 2) && !$past(key_pause, 3)
        && $past(osd_pause, 2) == $past(osd_pause, 3) && !$past(lock) && !$past(downloading)
        |-> game_pause != $past(game_pause))
        else begin
            err_cnt++;
            $error("Error at %0t: game_pause is %b, expected %b", $time, game_pause,
                   !$past(game_pause));
        end

    osd_follow: assert property (@(posedge clk) disable iff (rst)
        ready && $past(osd_pause, 2) != $past(osd_pause, 3) && !$past(lock)
        && !$past(downloading) |-> game_pause == $past(osd_pause, 2))
        else begin
            err_cnt++;
            $error("Error at %0t: game_pause is %b, expected %b", $time, game_pause,
                   $past(osd_pause, 2));
        end

    step_start: assert property (@(posedge clk) disable iff (rst)
        ready && $past(game_pause) && $past(key_service, 2) && !$past(key_service, 3)
        && !$past(lock) && !$past(downloading) |-> !game_pause)
        else begin
            err_cnt++;
            $error("Error at %0t: game_pause is %b, expected 0", $time, game_pause);
        end

    step_end: assert property (@(posedge clk) disable iff (rst)
        ready && $past(step_ref) && $past(vs, 2) && !$past(vs) && !$past(lock)
        |-> game_pause)
        else begin
            err_cnt++;
            $error("Error at %0t: game_pause is %b, expected 1", $time, game_pause);
        end

    soft_pulse: assert property (@(posedge clk) disable iff (rst)
        ready |-> soft_rst == ($past(key_reset, 2) && !$past(key_reset, 3)))
        else begin
            err_cnt++;
            $error("Error at %0t: soft_rst is %b, expected %b", $time, soft_rst,
                   $past(key_reset, 2) && !$past(key_reset, 3));
        end

    lock_blank: assert property (@(posedge clk) disable iff (rst)
        ready && $past(lock) |-> game_joy1 == {10{POL}}
        && game_joy2 == {10{POL}} && game_joy3 == {10{POL}} && game_joy4 == {10{POL}}
        && game_coin == {4{POL}} && game_start == {4{POL}}
        && game_service == POL && game_test == POL)
        else begin
            err_cnt++;
            $error("Error at %0t: a game output stayed active under lock", $time);
        end

    run_force: assert property (@(posedge clk) disable iff (rst)
        ready && ($past(lock) || $past(downloading)) |-> !game_pause)
        else begin
            err_cnt++;
            $error("Error at %0t: game_pause is %b, expected 0", $time, game_pause);
        end

endmodule

bind arcade_inputs_top arcade_inputs_props u_props (.*);

/* tb/tb_arcade_inputs.sv */
`timescale 1ns/1ns

module tb_arcade_inputs;
    import input_pkg::*;

    localparam int STIM_CYCLES = 260;
    localparam int CYCLE_LIMIT = 4 * STIM_CYCLES;

    logic         clk, rst, vs, dip_flip, rot_control, autofire0, downloading, en4way;
    logic         lock, key_pause, osd_pause, key_reset, key_service, key_test;
    board_joy_t   board_joy1, board_joy2, board_joy3, board_joy4;
    player_bits_t board_coin, board_start, key_coin, key_start;
    game_joy_t    key_joy1, key_joy2, key_joy3;
    game_joy_t    game_joy1, game_joy2, game_joy3, game_joy4;
    player_bits_t game_coin, game_start;
    logic         game_service, game_test, soft_rst, game_pause;
    logic [31:0]  seed;
    int           cycles;

    arcade_inputs_top DUT (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("CHECKS FAILED");
            $fatal(1, "timeout, run exceeded %0d cycles", CYCLE_LIMIT);
        end
    end

    always @(negedge clk) begin
        if (DUT.u_props.err_cnt != 0) begin
            $display("CHECKS FAILED");
            $fatal(1, "an assertion in the bound checker failed");
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic step_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // pause bits stay clear so random words never toggle pause
    task automatic randomize_words();
        seed       = lcg_next(seed);
        board_joy1 = {8'h00, seed[23:16]};
        board_joy2 = {8'h00, seed[31:24]};
        seed       = lcg_next(seed);
        board_joy3 = {8'h00, seed[23:16]};
        board_joy4 = {8'h00, seed[31:24]};
        key_coin   = seed[11:8];
        key_start  = seed[15:12];
        seed       = lcg_next(seed);
        key_joy1   = {2'b00, seed[23:16]};
        key_joy2   = {2'b00, seed[31:24]};
        key_joy3   = {2'b00, seed[15:8]};
        seed       = lcg_next(seed);
        board_coin  = seed[19:16];
        board_start = seed[23:20];
        key_test    = seed[27];
    endtask

    task automatic clear_words();
        {board_joy1, board_joy2, board_joy3, board_joy4} = '0;
        {key_joy1, key_joy2, key_joy3} = '0;
        {board_coin, board_start, key_coin, key_start} = '0;
        key_test = 1'b0;
    endtask

    task automatic run_frame();
        vs = 1'b1;
        step_cycles(3);
        vs = 1'b0;
        step_cycles(3);
    endtask

    task automatic pulse(ref logic sig, input int hold, input int gap);
        sig = 1'b1;
        step_cycles(hold);
        sig = 1'b0;
        step_cycles(gap);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        cycles = 0;
        seed = 32'd71;
        {vs, dip_flip, rot_control, autofire0, downloading, en4way} = '0;
        {lock, key_pause, osd_pause, key_reset, key_service, key_test} = '0;
        clear_words();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // random words under every rotation and flip setting
        for (int i = 0; i < 40; i++) begin
            rot_control = i[3];
            dip_flip    = i[4];
            randomize_words();
            step_cycles(1);
        end
        clear_words();

        en4way = 1'b1;
        board_joy1 = 16'h0001;   // up alone
        step_cycles(3);
        board_joy1 = 16'h0009;   // up and right
        step_cycles(3);
        board_joy1 = 16'h0006;   // up released with left and down held
        step_cycles(3);
        board_joy1 = 16'h0000;
        en4way = 1'b0;
        step_cycles(3);

        autofire0 = 1'b1;
        board_joy1 = 16'h0010;
        repeat (20) run_frame();
        autofire0 = 1'b0;
        board_joy1 = 16'h0000;
        step_cycles(2);

        pulse(key_pause, 3, 3);      // into pause
        pulse(key_service, 2, 2);    // one frame step
        run_frame();
        step_cycles(3);
        osd_pause = 1'b1;
        step_cycles(4);
        osd_pause = 1'b0;
        step_cycles(4);
        pulse(key_pause, 3, 3);
        lock = 1'b1;
        for (int i = 0; i < 6; i++) begin
            randomize_words();
            step_cycles(1);
        end
        lock = 1'b0;
        clear_words();
        step_cycles(3);
        pulse(key_reset, 3, 4);
        pulse(key_pause, 3, 3);      // paused again before the download
        pulse(downloading, 2, 4);

        if (DUT.u_props.err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "bound checker reported failures");
        end
    end

endmodule

/* sources.f */
+incdir+source
source/input_pkg.sv
source/pause_req_if.sv
source/joy_4way_filter.sv
source/frame_timer.sv
source/pause_fsm.sv
source/input_merger.sv
source/arcade_inputs_top.sv
tb/arcade_inputs_props.sv
tb/tb_arcade_inputs.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_arcade_inputs -o sim_tb

status=0
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation finished"
